// ==== hw/interp_pkg.sv ====
// Shared widths, tap constants, MAC opcodes and the stereo RAM word for the interpolator
`default_nettype none

package interp_pkg;

    // ----------------------------------------------------------------------
    // Data path widths
    // ----------------------------------------------------------------------
    localparam int SAMPLE_W = 18;
    localparam int ACC_W    = 48;

    // ----------------------------------------------------------------------
    // Filter geometry
    // ----------------------------------------------------------------------
    // Delay line depth equals the tap count
    localparam int NUM_TAPS   = 34;
    // Pass-through phase of the halfband
    localparam int MID_TAP    = 17;
    localparam int TAP_ADDR_W = 6;

    // ----------------------------------------------------------------------
    // MAC slice opcodes
    // ----------------------------------------------------------------------
    localparam int OP_W = 2;

    // Product zero, accumulator cleared
    localparam logic [OP_W-1:0] MAC_NOP = 2'd0;
    // Load product, starts a new sum
    localparam logic [OP_W-1:0] MAC_MUL = 2'd1;
    // Add product to accumulator
    localparam logic [OP_W-1:0] MAC_ACC = 2'd2;

    // One delay-line word, seen flat by the RAM and as a pair by the sequencer
    typedef union packed {
        logic [2*SAMPLE_W-1:0] raw;
        struct packed {
            logic signed [SAMPLE_W-1:0] l;
            logic signed [SAMPLE_W-1:0] r;
        } pair;
    } stereo_word_u;

endpackage

`default_nettype wire

// ==== hw/dp_ram.sv ====
// Dual-port RAM with synchronous write and registered read, used as the delay line
`timescale 1ns/1ps
`default_nettype none

module dp_ram #(
    parameter int DATA_W = 36,
    parameter int ADDR_W = 6,
    parameter int DEPTH  = 34
) (
    input  logic              reset,
    input  logic              clk,
    input  logic              wr,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic              rd,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge reset) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port holds its word between reads
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            rd_data <= '0;
        end else if (rd) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/dsp_mac.sv ====
// Two-stage signed multiply-accumulate slice controlled by a small opcode
`timescale 1ns/1ps
`default_nettype none

module dsp_mac (
    input  logic                                  reset,
    input  logic                                  clk,
    input  logic [interp_pkg::OP_W-1:0]           op,
    input  logic signed [interp_pkg::SAMPLE_W-1:0] a,
    input  logic signed [interp_pkg::SAMPLE_W-1:0] b,
    output logic signed [interp_pkg::ACC_W-1:0]    p
);

    import interp_pkg::*;

    logic [OP_W-1:0]              op_q;
    logic signed [SAMPLE_W-1:0]   a_q;
    logic signed [SAMPLE_W-1:0]   b_q;
    logic signed [2*SAMPLE_W-1:0] prod;

    // ----------------------------------------------------------------------
    // Stage 1, operand registers
    // ----------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            op_q <= MAC_NOP;
        end else begin
            op_q <= op;
        end
    end

    always_ff @(posedge reset) begin
        a_q <= a;
        b_q <= b;
    end

    // ----------------------------------------------------------------------
    // Stage 2, product and accumulator
    // ----------------------------------------------------------------------
    assign prod = a_q * b_q;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            p <= '0;
        end else begin
            case (op_q)
                MAC_MUL: p <= ACC_W'(prod);
                MAC_ACC: p <= p + ACC_W'(prod);
                // NOP and the unused code clear the sum
                default: p <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/fir_interp_halfband_2x.sv ====
// Microcoded sequencer of the stereo halfband 2x interpolator with delay line control
`timescale 1ns/1ps
`default_nettype none

module fir_interp_halfband_2x (
    input  logic                                   reset,
    input  logic                                   clk,
    input  logic                                   in_valid,
    input  logic signed [interp_pkg::SAMPLE_W-1:0] in_l,
    input  logic signed [interp_pkg::SAMPLE_W-1:0] in_r,
    output logic                                   in_credit,
    output logic                                   out_valid,
    output logic signed [interp_pkg::SAMPLE_W-1:0] out_l,
    output logic signed [interp_pkg::SAMPLE_W-1:0] out_r,
    output logic                                   done,
    output logic                                   ram_wr,
    output logic [interp_pkg::TAP_ADDR_W-1:0]      ram_wr_addr,
    output interp_pkg::stereo_word_u               ram_wr_data,
    output logic                                   ram_rd,
    output logic [interp_pkg::TAP_ADDR_W-1:0]      ram_rd_addr,
    input  interp_pkg::stereo_word_u               ram_rd_data,
    output logic [interp_pkg::OP_W-1:0]            op_l,
    output logic signed [interp_pkg::SAMPLE_W-1:0] a_l,
    output logic signed [interp_pkg::SAMPLE_W-1:0] b_l,
    output logic [interp_pkg::OP_W-1:0]            op_r,
    output logic signed [interp_pkg::SAMPLE_W-1:0] a_r,
    output logic signed [interp_pkg::SAMPLE_W-1:0] b_r,
    input  logic signed [interp_pkg::ACC_W-1:0]    p_l,
    input  logic signed [interp_pkg::ACC_W-1:0]    p_r
);

    import interp_pkg::*;

    localparam int TASK_W  = 16;
    localparam int OUT_LSB = 16;
    localparam logic [TAP_ADDR_W-1:0] LAST_ADDR = TAP_ADDR_W'(NUM_TAPS - 1);
    localparam logic [3:0]            PC_WAIT   = 4'd2;

    // ----------------------------------------------------------------------
    // Task bits, one-hot, OR-ed together per program step
    // ----------------------------------------------------------------------
    localparam logic [TASK_W-1:0] T_NOP         = 16'h0000;
    localparam logic [TASK_W-1:0] T_WAIT_IN     = 16'h0001;
    localparam logic [TASK_W-1:0] T_PUSH_X      = 16'h0002;
    localparam logic [TASK_W-1:0] T_MOV_I_0     = 16'h0004;
    localparam logic [TASK_W-1:0] T_INC_I       = 16'h0008;
    localparam logic [TASK_W-1:0] T_MOV_J_HEAD  = 16'h0010;
    localparam logic [TASK_W-1:0] T_INC_J_CIRC  = 16'h0020;
    localparam logic [TASK_W-1:0] T_MAC_CI_XJ   = 16'h0040;
    localparam logic [TASK_W-1:0] T_READ_XMID   = 16'h0080;
    localparam logic [TASK_W-1:0] T_MOV_RES_AC  = 16'h0100;
    localparam logic [TASK_W-1:0] T_MOV_RES_MID = 16'h0200;
    localparam logic [TASK_W-1:0] T_REPEAT_TAPS = 16'h0400;
    localparam logic [TASK_W-1:0] T_JP_WAIT     = 16'h0800;
    localparam logic [TASK_W-1:0] T_DONE        = 16'h1000;
    localparam logic [TASK_W-1:0] T_CREDIT      = 16'h2000;

    logic [3:0]                 pc;
    logic [TASK_W-1:0]          tasks;
    logic [TAP_ADDR_W-1:0]      rpt_cnt;
    logic [TAP_ADDR_W-1:0]      rpt_max;
    logic                       rpt_busy;
    logic [TAP_ADDR_W-1:0]      i_reg;
    logic [TAP_ADDR_W-1:0]      j_reg;
    logic [TAP_ADDR_W-1:0]      head_ptr;
    logic [TAP_ADDR_W-1:0]      mid_ptr;
    logic [TAP_ADDR_W-1:0]      head_next;
    logic [TAP_ADDR_W-1:0]      mid_next;
    logic [TAP_ADDR_W-1:0]      coef_idx;
    logic signed [SAMPLE_W-1:0] ci;
    logic signed [SAMPLE_W-1:0] coef_q;
    logic [OP_W-1:0]            mac_op_q;
    stereo_word_u               in_word;

    // Task table
    always_comb begin
        case (pc)
            // Clear delay line with zeros
            4'd0:    tasks = T_REPEAT_TAPS | T_PUSH_X;
            4'd1:    tasks = T_CREDIT;
            4'd2:    tasks = T_WAIT_IN;
            4'd3:    tasks = T_PUSH_X | T_MOV_I_0 | T_MOV_J_HEAD;
            4'd4:    tasks = T_REPEAT_TAPS | T_MAC_CI_XJ | T_INC_I | T_INC_J_CIRC;
            // Drain RAM read and both MAC stages
            4'd5:    tasks = T_NOP;
            4'd6:    tasks = T_NOP;
            4'd7:    tasks = T_MOV_RES_AC | T_READ_XMID;
            4'd8:    tasks = T_MOV_RES_MID | T_DONE;
            4'd9:    tasks = T_CREDIT | T_JP_WAIT;
            default: tasks = T_JP_WAIT;
        endcase
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pc <= 4'd0;
        end else if (|(tasks & T_JP_WAIT)) begin
            pc <= PC_WAIT;
        end else if ((|(tasks & T_WAIT_IN) && !in_valid) ||
                     (|(tasks & T_REPEAT_TAPS) && rpt_busy)) begin
            pc <= pc;
        end else begin
            pc <= pc + 4'd1;
        end
    end

    // Repeat counter for the 34-step loops
    assign rpt_max  = |(tasks & T_REPEAT_TAPS) ? LAST_ADDR : '0;
    assign rpt_busy = (rpt_cnt != rpt_max);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            rpt_cnt <= '0;
        end else if (!rpt_busy) begin
            rpt_cnt <= '0;
        end else begin
            rpt_cnt <= rpt_cnt + 1'b1;
        end
    end

    // Input pair, taken only while waiting
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            in_word.raw <= '0;
        end else if (|(tasks & T_WAIT_IN) && in_valid) begin
            in_word.pair.l <= in_l;
            in_word.pair.r <= in_r;
        end
    end

    // ----------------------------------------------------------------------
    // Index registers and delay line pointers
    // ----------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            i_reg <= '0;
        end else if (|(tasks & T_MOV_I_0)) begin
            i_reg <= '0;
        end else if (|(tasks & T_INC_I)) begin
            i_reg <= i_reg + 1'b1;
        end
    end

    // j starts at the newest sample and walks towards older ones
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            j_reg <= '0;
        end else if (|(tasks & T_MOV_J_HEAD)) begin
            j_reg <= head_next;
        end else if (|(tasks & T_INC_J_CIRC)) begin
            j_reg <= (j_reg == LAST_ADDR) ? '0 : j_reg + 1'b1;
        end
    end

    assign head_next = (head_ptr == '0) ? LAST_ADDR : head_ptr - 1'b1;
    assign mid_next  = (mid_ptr == '0) ? LAST_ADDR : mid_ptr - 1'b1;

    // Head points at the newest sample, mid stays MID_TAP behind it
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            head_ptr <= '0;
            mid_ptr  <= TAP_ADDR_W'(MID_TAP);
        end else if (|(tasks & T_PUSH_X)) begin
            head_ptr <= head_next;
            mid_ptr  <= mid_next;
        end
    end

    assign ram_wr      = |(tasks & T_PUSH_X);
    assign ram_wr_addr = head_next;
    assign ram_wr_data = in_word;
    assign ram_rd      = |(tasks & (T_MAC_CI_XJ | T_READ_XMID));
    assign ram_rd_addr = |(tasks & T_READ_XMID) ? mid_ptr : j_reg;

    // ----------------------------------------------------------------------
    // Coefficients, symmetric so only half is stored
    // ----------------------------------------------------------------------
    assign coef_idx = (i_reg < TAP_ADDR_W'(NUM_TAPS / 2)) ? i_reg : LAST_ADDR - i_reg;

    always_comb begin
        case (coef_idx)
            6'd0:    ci = 18'sh00002;
            6'd1:    ci = 18'sh3FFF6;
            6'd2:    ci = 18'sh0001A;
            6'd3:    ci = 18'sh3FFC5;
            6'd4:    ci = 18'sh00071;
            6'd5:    ci = 18'sh3FF36;
            6'd6:    ci = 18'sh0014E;
            6'd7:    ci = 18'sh3FDEF;
            6'd8:    ci = 18'sh00322;
            6'd9:    ci = 18'sh3FB62;
            6'd10:   ci = 18'sh006A5;
            6'd11:   ci = 18'sh3F68B;
            6'd12:   ci = 18'sh00D71;
            6'd13:   ci = 18'sh3EC88;
            6'd14:   ci = 18'sh01DC3;
            6'd15:   ci = 18'sh3CB6A;
            6'd16:   ci = 18'sh0A263;
            default: ci = '0;
        endcase
    end

    // Opcode and coefficient delayed to meet the RAM read data
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            mac_op_q <= MAC_NOP;
        end else if (|(tasks & T_MAC_CI_XJ)) begin
            mac_op_q <= (i_reg == '0) ? MAC_MUL : MAC_ACC;
        end else begin
            mac_op_q <= MAC_NOP;
        end
    end

    always_ff @(posedge reset) begin
        coef_q <= ci;
    end

    assign op_l = mac_op_q;
    assign op_r = mac_op_q;
    assign a_l  = coef_q;
    assign a_r  = coef_q;
    assign b_l  = ram_rd_data.pair.l;
    assign b_r  = ram_rd_data.pair.r;

    // ----------------------------------------------------------------------
    // Results, done and credit
    // ----------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            out_valid <= 1'b0;
            out_l     <= '0;
            out_r     <= '0;
        end else if (|(tasks & T_MOV_RES_AC)) begin
            out_valid <= 1'b1;
            out_l     <= p_l[OUT_LSB+SAMPLE_W-1:OUT_LSB];
            out_r     <= p_r[OUT_LSB+SAMPLE_W-1:OUT_LSB];
        end else if (|(tasks & T_MOV_RES_MID)) begin
            out_valid <= 1'b1;
            out_l     <= ram_rd_data.pair.l;
            out_r     <= ram_rd_data.pair.r;
        end else begin
            out_valid <= 1'b0;
            out_l     <= '0;
            out_r     <= '0;
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            done      <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            done      <= |(tasks & T_DONE);
            in_credit <= |(tasks & T_CREDIT);
        end
    end

endmodule

`default_nettype wire

// ==== hw/interp_top.sv ====
// Top level of the stereo halfband 2x interpolator: sequencer, delay RAM and two MAC slices
`timescale 1ns/1ps
`default_nettype none

module interp_top #(
    parameter int RAM_DATA_W = 2 * interp_pkg::SAMPLE_W,
    parameter int RAM_ADDR_W = interp_pkg::TAP_ADDR_W,
    parameter int RAM_DEPTH  = interp_pkg::NUM_TAPS
) (
    input  logic                                   reset,
    input  logic                                   clk,
    input  logic                                   in_valid,
    input  logic signed [interp_pkg::SAMPLE_W-1:0] in_l,
    input  logic signed [interp_pkg::SAMPLE_W-1:0] in_r,
    output logic                                   in_credit,
    output logic                                   out_valid,
    output logic                                   done,
    output logic signed [interp_pkg::SAMPLE_W-1:0] out_l,
    output logic signed [interp_pkg::SAMPLE_W-1:0] out_r
);

    import interp_pkg::*;

    logic                       ram_wr;
    logic                       ram_rd;
    logic [RAM_ADDR_W-1:0]      ram_wr_addr;
    logic [RAM_ADDR_W-1:0]      ram_rd_addr;
    logic [RAM_DATA_W-1:0]      ram_wr_data;
    logic [RAM_DATA_W-1:0]      ram_rd_data;
    logic [OP_W-1:0]            op_l;
    logic [OP_W-1:0]            op_r;
    logic signed [SAMPLE_W-1:0] a_l;
    logic signed [SAMPLE_W-1:0] b_l;
    logic signed [SAMPLE_W-1:0] a_r;
    logic signed [SAMPLE_W-1:0] b_r;
    logic signed [ACC_W-1:0]    p_l;
    logic signed [ACC_W-1:0]    p_r;

    fir_interp_halfband_2x i_seq (
        .reset       (reset),
        .clk         (clk),
        .in_valid    (in_valid),
        .in_l        (in_l),
        .in_r        (in_r),
        .in_credit   (in_credit),
        .out_valid   (out_valid),
        .out_l       (out_l),
        .out_r       (out_r),
        .done        (done),
        .ram_wr      (ram_wr),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_data (ram_wr_data),
        .ram_rd      (ram_rd),
        .ram_rd_addr (ram_rd_addr),
        .ram_rd_data (ram_rd_data),
        .op_l        (op_l),
        .a_l         (a_l),
        .b_l         (b_l),
        .op_r        (op_r),
        .a_r         (a_r),
        .b_r         (b_r),
        .p_l         (p_l),
        .p_r         (p_r)
    );

    // Circular delay line, one stereo pair per word
    dp_ram #(
        .DATA_W (RAM_DATA_W),
        .ADDR_W (RAM_ADDR_W),
        .DEPTH  (RAM_DEPTH)
    ) i_delay_ram (
        .reset   (reset),
        .clk     (clk),
        .wr      (ram_wr),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_wr_data),
        .rd      (ram_rd),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data)
    );

    dsp_mac i_mac_l (
        .reset (reset),
        .clk   (clk),
        .op    (op_l),
        .a     (a_l),
        .b     (b_l),
        .p     (p_l)
    );

    dsp_mac i_mac_r (
        .reset (reset),
        .clk   (clk),
        .op    (op_r),
        .a     (a_r),
        .b     (b_r),
        .p     (p_r)
    );

endmodule

`default_nettype wire

// ==== test/tb_interp_model.svh ====
// Interpolator reference model with per-channel tap history and expected output pairs
`ifndef TB_INTERP_MODEL_SVH
`define TB_INTERP_MODEL_SVH

localparam int MODEL_TAPS = 34;
localparam int MODEL_MID  = 17;

// Newest sample at index 0
logic signed [17:0] hist_l [MODEL_TAPS];
logic signed [17:0] hist_r [MODEL_TAPS];

// Symmetric halfband table, first half listed
function automatic logic signed [17:0] coef(input int k);
    int                 h;
    logic signed [17:0] c;
    h = (k < MODEL_TAPS / 2) ? k : MODEL_TAPS - 1 - k;
    case (h)
        0:       c = 18'sh00002;
        1:       c = 18'sh3FFF6;
        2:       c = 18'sh0001A;
        3:       c = 18'sh3FFC5;
        4:       c = 18'sh00071;
        5:       c = 18'sh3FF36;
        6:       c = 18'sh0014E;
        7:       c = 18'sh3FDEF;
        8:       c = 18'sh00322;
        9:       c = 18'sh3FB62;
        10:      c = 18'sh006A5;
        11:      c = 18'sh3F68B;
        12:      c = 18'sh00D71;
        13:      c = 18'sh3EC88;
        14:      c = 18'sh01DC3;
        15:      c = 18'sh3CB6A;
        16:      c = 18'sh0A263;
        default: c = '0;
    endcase
    return c;
endfunction

task automatic clear_history();
    int k;
    for (k = 0; k < MODEL_TAPS; k++) begin
        hist_l[k] = '0;
        hist_r[k] = '0;
    end
endtask

task automatic push_history(input logic signed [17:0] l, input logic signed [17:0] r);
    int k;
    for (k = MODEL_TAPS - 1; k > 0; k--) begin
        hist_l[k] = hist_l[k-1];
        hist_r[k] = hist_r[k-1];
    end
    hist_l[0] = l;
    hist_r[0] = r;
endtask

// Filtered value in the upper half, mid-tap sample in the lower half
function automatic logic [35:0] reference_pair(input bit right);
    longint             acc;
    logic [63:0]        acc_bits;
    logic signed [17:0] s;
    int                 k;
    acc = 0;
    for (k = 0; k < MODEL_TAPS; k++) begin
        s = right ? hist_r[k] : hist_l[k];
        acc += longint'(coef(k)) * longint'(s);
    end
    acc_bits = acc;
    s = right ? hist_r[MODEL_MID] : hist_l[MODEL_MID];
    return {acc_bits[33:16], s};
endfunction

`endif

// ==== test/tb_interp_top.sv ====
// Testbench of the stereo halfband interpolator with credit-driven stimulus and a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_interp_top;

    localparam int HALF_PERIOD    = 10;
    localparam int CREDIT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 400;

    // Port reset carries the clock and port clk the active-high reset
    logic               reset;
    logic               clk;
    logic               in_valid;
    logic signed [17:0] in_l;
    logic signed [17:0] in_r;
    logic               in_credit;
    logic               out_valid;
    logic               done;
    logic signed [17:0] out_l;
    logic signed [17:0] out_r;

    logic signed [17:0] exp_l [$];
    logic signed [17:0] exp_r [$];
    int                 seed           = 32'h3ba5ee21;
    int                 compare_errors = 0;
    int                 compare_checks = 0;
    int                 stim_errors    = 0;
    int                 stim_checks    = 0;
    int                 strobe_count   = 0;
    int                 done_count     = 0;
    int                 credit_count   = 0;
    int                 sent_count     = 0;
    bit                 abort          = 0;

    `include "tb_interp_model.svh"

    interp_top i_dut (
        .reset     (reset),
        .clk       (clk),
        .in_valid  (in_valid),
        .in_l      (in_l),
        .in_r      (in_r),
        .in_credit (in_credit),
        .out_valid (out_valid),
        .done      (done),
        .out_l     (out_l),
        .out_r     (out_r)
    );

    initial begin
        reset = 1'b0;
        forever #HALF_PERIOD reset = ~reset;
    end

    // ----------------------------------------------------------------------
    // Output compare and strobe ordering
    // ----------------------------------------------------------------------
    always @(posedge reset) begin
        logic signed [17:0] want_l;
        logic signed [17:0] want_r;
        if (!clk) begin
            if (out_valid) begin
                strobe_count++;
                if (exp_l.size() == 0) begin
                    $display("Output strobe at %0t with no expected value left", $time);
                    compare_errors++;
                end else begin
                    want_l = exp_l.pop_front();
                    want_r = exp_r.pop_front();
                    compare_checks++;
                    if (out_l !== want_l) begin
                        $display("FAIL t=%0t out_l expected %0d got %0d", $time, want_l, out_l);
                        compare_errors++;
                    end
                    if (out_r !== want_r) begin
                        $display("FAIL t=%0t out_r expected %0d got %0d", $time, want_r, out_r);
                        compare_errors++;
                    end
                end
            end
            if (done) begin
                done_count++;
                if (!out_valid || strobe_count != 2 * done_count) begin
                    $display("done at %0t is not on the second output of its input", $time);
                    compare_errors++;
                end
            end
            if (in_credit) begin
                if (credit_count != done_count) begin
                    $display("Credit at %0t came before the previous input was done", $time);
                    compare_errors++;
                end
                credit_count++;
            end
        end
    end

    task automatic expect_value(input string name, input int actual, input int expected);
        stim_checks++;
        if (actual != expected) begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            stim_errors++;
        end
    endtask

    // A credit is free while more credits than inputs have been seen
    task automatic wait_credit();
        int n;
        @(negedge reset);
        for (n = 0; n < CREDIT_TIMEOUT && credit_count <= sent_count; n++) begin
            @(negedge reset);
        end
        if (credit_count <= sent_count) begin
            $display("Timed out at %0t waiting for a credit", $time);
            stim_errors++;
            abort = 1;
        end
    endtask

    task automatic wait_drain();
        int n;
        if (abort) return;
        @(negedge reset);
        for (n = 0; n < DRAIN_TIMEOUT && done_count < sent_count; n++) begin
            @(negedge reset);
        end
        if (done_count < sent_count) begin
            $display("Timed out at %0t waiting for the outputs of input %0d", $time, done_count);
            stim_errors++;
            abort = 1;
        end
    endtask

    task automatic send_pair(input logic signed [17:0] l, input logic signed [17:0] r,
                             input int gap);
        logic [35:0] ref_l;
        logic [35:0] ref_r;
        if (abort) return;
        wait_credit();
        if (abort) return;
        @(posedge reset);
        repeat (gap) @(posedge reset);
        push_history(l, r);
        ref_l = reference_pair(1'b0);
        ref_r = reference_pair(1'b1);
        exp_l.push_back(ref_l[35:18]);
        exp_l.push_back(ref_l[17:0]);
        exp_r.push_back(ref_r[35:18]);
        exp_r.push_back(ref_r[17:0]);
        in_valid <= 1'b1;
        in_l     <= l;
        in_r     <= r;
        sent_count++;
        @(posedge reset);
        in_valid <= 1'b0;
        in_l     <= '0;
        in_r     <= '0;
    endtask

    task automatic check_reset_state();
        int n;
        bit got;
        got = 0;
        for (n = 0; n < CREDIT_TIMEOUT && !got; n++) begin
            @(posedge reset);
            got = in_credit;
            if (!got) begin
                expect_value("out_valid", int'(out_valid), 0);
                expect_value("done", int'(done), 0);
                expect_value("out_l", int'(out_l), 0);
                expect_value("out_r", int'(out_r), 0);
            end
        end
        if (!got) begin
            $display("Timed out at %0t waiting for the first credit", $time);
            stim_errors++;
            abort = 1;
            return;
        end
        // No second credit while the first is unused
        repeat (10) begin
            @(posedge reset);
            expect_value("in_credit", int'(in_credit), 0);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        int failed;
        @(negedge reset);
        failed = compare_errors + stim_errors - errors_before;
        if (failed == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, failed);
        end
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        int          base;
        int          n;
        int          gap;
        logic [31:0] rnd;
        in_valid = 1'b0;
        in_l     = '0;
        in_r     = '0;
        clk      = 1'b1;
        clear_history();
        repeat (2) @(posedge reset);
        clk <= 1'b0;

        base = 0;
        check_reset_state();
        end_test("reset state", base);

        base = compare_errors + stim_errors;
        send_pair(18'sh1FFFF, 18'sh00000, 0);
        for (n = 0; n < 35 && !abort; n++) begin
            send_pair(18'sh00000, 18'sh00000, 0);
        end
        wait_drain();
        end_test("impulse response", base);

        base = compare_errors + stim_errors;
        for (n = 0; n < 200 && !abort; n++) begin
            rnd = $random(seed);
            send_pair(rnd[17:0], rnd[31:14], 0);
        end
        wait_drain();
        end_test("random stereo stream", base);

        base = compare_errors + stim_errors;
        for (n = 0; n < 20 && !abort; n++) begin
            rnd = $random(seed);
            send_pair(rnd[17:0], rnd[31:14], 0);
            // Uncredited pulse during the MAC loop
            repeat (4) @(posedge reset);
            in_valid <= 1'b1;
            in_l     <= 18'sh15555;
            in_r     <= 18'sh2AAAA;
            @(posedge reset);
            in_valid <= 1'b0;
            in_l     <= '0;
            in_r     <= '0;
            wait_drain();
            expect_value("output strobes", strobe_count, 2 * done_count);
            expect_value("accepted inputs", done_count, sent_count);
        end
        end_test("output ordering", base);

        base = compare_errors + stim_errors;
        for (n = 0; n < 50 && !abort; n++) begin
            rnd = $random(seed);
            gap = int'(rnd % 32'd11);
            rnd = $random(seed);
            send_pair(rnd[17:0], rnd[31:14], gap);
        end
        wait_drain();
        expect_value("pending outputs", exp_l.size(), 0);
        end_test("delayed sending", base);

        $display("inputs %0d, output checks %0d, other checks %0d, errors %0d",
                 sent_count, compare_checks, stim_checks, compare_errors + stim_errors);
        if (compare_errors + stim_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+test
hw/interp_pkg.sv
hw/dp_ram.sv
hw/dsp_mac.sv
hw/fir_interp_halfband_2x.sv
hw/interp_top.sv
test/tb_interp_top.sv

// ==== Makefile ====
# Verilator build and run of the interpolator testbench

VERILATOR ?= verilator
TOP       ?= tb_interp_top
FILELIST  ?= files.f
BUILD_DIR ?= ./obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= *** PASSED ***

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides the result, not the simulator's exit status
run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF -- '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
